// ==== build.sh ====
#!/bin/sh
# compile the pulse duration timer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f duration_timer.f --top-module duration_timer_tb \
	--Mdir obj_dir -o duration_timer_sim
if [ $? -ne 0 ]; then
	echo "build.sh: verilator compile failed"
	exit 1
fi

output=$(./obj_dir/duration_timer_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "build.sh: simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

// ==== duration_timer.f ====
+incdir+hw
hw/duration_timer_pkg.sv
hw/timer_config.sv
hw/pulse_duration_meter.sv
hw/bin_to_bcd.sv
hw/report_formatter.sv
hw/uart_tx.sv
hw/segment_display.sv
hw/duration_timer_top.sv
dv/duration_timer_tb.sv

// ==== dv/duration_timer_tb.sv ====
/*
 * directed testbench for the pulse duration timer
 * clock and reset, register access, uart line decoder, display scan check
 */
`timescale 1ns/1ps
`include "duration_timer_params.svh"
`default_nettype none

module duration_timer_tb;

	localparam int WAIT_LIMIT = 20000; // cycles allowed for any single wait

	logic clock;
	logic reset;
	logic trigger;
	logic cfg_write;
	duration_timer_pkg::cfg_address_t cfg_address;
	duration_timer_pkg::cfg_data_t cfg_write_data;
	duration_timer_pkg::cfg_data_t cfg_read_data;
	logic tx;
	logic [6:0] segment;
	logic [3:0] anode;

	int value_errors;
	int other_errors;
	int quiet_errors = 0; // tx activity seen by the idle line monitor
	int baud_setting; // divisor currently programmed
	int expected_count; // pulses seen by the meter so far
	int last_width;
	logic [31:0] random_state;
	logic expect_quiet; // tx must stay idle while set

	duration_timer_top uut (.clock(clock), .reset(reset), .trigger(trigger),
		.cfg_write(cfg_write), .cfg_address(cfg_address), .cfg_write_data(cfg_write_data),
		.cfg_read_data(cfg_read_data), .tx(tx), .segment(segment), .anode(anode));

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(negedge clock) begin
		if (expect_quiet) begin
			assert (tx === 1'b1) else begin
				$display("ERR tx: got %h expected %h while no line is due", tx, 1'b1);
				quiet_errors++;
			end
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] value);
		logic [31:0] x;
		x = value;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int decimal_digit(input int value, input int position);
		int scaled;
		scaled = value;
		for (int i = 0; i < position; i++) begin
			scaled = scaled / 10;
		end
		return scaled % 10;
	endfunction

	// character of the report line at a given index
	function automatic duration_timer_pkg::byte_t expected_char(input int index, input int dur,
			input int cnt);
		if (index < 6) return 8'(48 + decimal_digit(dur, 5 - index));
		if (index == 6) return 8'h20;
		if (index < 13) return 8'(48 + decimal_digit(cnt, 12 - index));
		if (index == 13) return 8'h0d;
		return 8'h0a;
	endfunction

	function automatic logic [6:0] segment_pattern(input int digit);
		case (digit) // segment a in bit 0
			0: return 7'h3f;
			1: return 7'h06;
			2: return 7'h5b;
			3: return 7'h4f;
			4: return 7'h66;
			5: return 7'h6d;
			6: return 7'h7d;
			7: return 7'h07;
			8: return 7'h7f;
			9: return 7'h6f;
			default: return 7'h00;
		endcase
	endfunction

	function automatic duration_timer_pkg::cfg_data_t status_value(input int count,
			input logic busy);
		return {12'(count), 3'd0, busy};
	endfunction

	task automatic next_cycle;
		@(posedge clock);
		#10;
	endtask

	task automatic idle_cycles(input int cycles);
		repeat (cycles) next_cycle();
	endtask

	task automatic write_register(input duration_timer_pkg::cfg_address_t address,
			input duration_timer_pkg::cfg_data_t data);
		next_cycle();
		cfg_write = 1'b1;
		cfg_address = address;
		cfg_write_data = data;
		next_cycle();
		cfg_write = 1'b0;
	endtask

	task automatic read_register(input duration_timer_pkg::cfg_address_t address,
			output duration_timer_pkg::cfg_data_t data);
		next_cycle();
		cfg_address = address;
		#50; // read mux settles
		data = cfg_read_data;
	endtask

	task automatic check_register(input duration_timer_pkg::cfg_address_t address,
			input duration_timer_pkg::cfg_data_t expected);
		duration_timer_pkg::cfg_data_t got;
		read_register(address, got);
		assert (got === expected) else begin
			$display("ERR cfg_read_data at address %h: got %h expected %h", address, got,
				expected);
			value_errors++;
		end
	endtask

	task automatic drive_pulse(input int width);
		next_cycle();
		trigger = 1'b1;
		repeat (width) @(posedge clock);
		#10;
		trigger = 1'b0;
		if (expected_count < 999999) expected_count++; // count saturates
	endtask

	// one 8N1 byte sampled mid-bit
	task automatic uart_receive(output duration_timer_pkg::byte_t data, output logic ok);
		int waited;
		ok = 1'b0;
		data = '0;
		waited = 0;
		do begin
			next_cycle();
			waited++;
		end while (tx !== 1'b0 && waited < WAIT_LIMIT);
		if (tx !== 1'b0) begin
			$display("timeout waiting for a uart start bit");
			other_errors++;
			return;
		end
		repeat (baud_setting / 2) next_cycle();
		if (tx !== 1'b0) begin
			$display("uart start bit ended before the middle of the bit");
			other_errors++;
			return;
		end
		for (int i = 0; i < 8; i++) begin
			repeat (baud_setting) next_cycle();
			data[i] = tx; // lsb first
		end
		repeat (baud_setting) next_cycle();
		if (tx !== 1'b1) begin
			$display("uart stop bit missing");
			other_errors++;
			return;
		end
		ok = 1'b1;
	endtask

	task automatic check_line(input int dur, input int cnt);
		duration_timer_pkg::byte_t got;
		duration_timer_pkg::byte_t expected;
		logic ok;
		for (int i = 0; i < `LINE_LENGTH; i++) begin
			uart_receive(got, ok);
			if (!ok) return;
			expected = expected_char(i, dur, cnt);
			assert (got === expected) else begin
				$display("ERR tx byte %0d: got %h expected %h", i, got, expected);
				value_errors++;
			end
		end
	endtask

	task automatic wait_line_idle;
		duration_timer_pkg::cfg_data_t status;
		int waited;
		waited = 0;
		do begin
			read_register(`ADDR_STATUS, status);
			waited++;
		end while (status[0] !== 1'b0 && waited < WAIT_LIMIT);
		if (status[0] !== 1'b0) begin
			$display("timeout waiting for the report line to finish");
			other_errors++;
		end
	endtask

	task automatic report_pulse(input int width);
		drive_pulse(width);
		check_line(width, expected_count);
		wait_line_idle();
		last_width = width;
		idle_cycles(50);
	endtask

	task automatic check_digits(input int value);
		int waited;
		for (int k = 0; k < 4; k++) begin
			waited = 0;
			do begin
				next_cycle();
				waited++;
			end while (anode !== (4'b0001 << k) && waited < WAIT_LIMIT);
			if (anode !== (4'b0001 << k)) begin
				$display("timeout waiting for display digit %0d to become active", k);
				other_errors++;
				return;
			end
			assert (segment === segment_pattern(decimal_digit(value, k))) else begin
				$display("ERR segment on digit %0d: got %h expected %h", k, segment,
					segment_pattern(decimal_digit(value, k)));
				value_errors++;
			end
		end
	endtask

	task automatic reset_defaults;
		expect_quiet = 1'b1;
		idle_cycles(20);
		check_register(`ADDR_BAUD, `DEFAULT_BAUD_DIVISOR);
		check_register(`ADDR_CONTROL, 16'h0000);
		check_register(`ADDR_STATUS, 16'h0000);
		expect_quiet = 1'b0;
	endtask

	task automatic register_access;
		write_register(`ADDR_BAUD, 16'h0008);
		baud_setting = 8;
		check_register(`ADDR_BAUD, 16'h0008);
		write_register(`ADDR_CONTROL, 16'h0002);
		check_register(`ADDR_CONTROL, 16'h0002);
		write_register(`ADDR_CONTROL, 16'h0000);
		write_register(`ADDR_STATUS, 16'hffff); // read only
		check_register(`ADDR_STATUS, 16'h0000);
		check_register(`ADDR_BAUD, 16'h0008);
		check_register(`ADDR_CONTROL, 16'h0000);
	endtask

	task automatic single_report;
		write_register(`ADDR_CONTROL, 16'h0001);
		report_pulse(37);
		check_register(`ADDR_STATUS, status_value(1, 1'b0));
	endtask

	task automatic random_reports;
		int width;
		for (int i = 0; i < 5; i++) begin
			random_state = xorshift32(random_state);
			width = int'(random_state % 32'd300) + 1;
			report_pulse(width);
		end
	endtask

	task automatic disabled_reports;
		int start_count;
		start_count = expected_count;
		write_register(`ADDR_CONTROL, 16'h0000);
		expect_quiet = 1'b1;
		drive_pulse(5);
		idle_cycles(40);
		drive_pulse(12);
		idle_cycles(40);
		drive_pulse(120);
		idle_cycles(400); // longer than the line latency
		expect_quiet = 1'b0;
		check_register(`ADDR_STATUS, status_value(start_count + 3, 1'b0));
		write_register(`ADDR_CONTROL, 16'h0001);
		report_pulse(1234);
	endtask

	task automatic display_scan;
		write_register(`ADDR_CONTROL, 16'h0001);
		check_digits(last_width);
		write_register(`ADDR_CONTROL, 16'h0003);
		check_digits(expected_count);
	endtask

	initial begin
		reset = 1'b1;
		trigger = 1'b0;
		cfg_write = 1'b0;
		cfg_address = '0;
		cfg_write_data = '0;
		value_errors = 0;
		other_errors = 0;
		baud_setting = int'(`DEFAULT_BAUD_DIVISOR);
		expected_count = 0;
		last_width = 0;
		random_state = 32'd82269;
		expect_quiet = 1'b0;
		repeat (10) @(posedge clock);
		#10;
		reset = 1'b0;

		reset_defaults();
		register_access();
		single_report();
		random_reports();
		disabled_reports();
		display_scan();

		value_errors = value_errors + quiet_errors;
		$display("error counts: %0d wrong values, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/bin_to_bcd.sv ====
/*
 * sequential double-dabble converter, 20 bit binary to six bcd digits
 * four-phase req/ack handshake
 */
`timescale 1ns/1ps
`include "duration_timer_params.svh"
`default_nettype none

module bin_to_bcd (
	input wire clock,
	input wire reset,
	input wire convert_req,
	input duration_timer_pkg::count_t convert_value,
	output logic convert_ack,
	output duration_timer_pkg::bcd_t convert_result
);

	duration_timer_pkg::convert_state_t state;
	duration_timer_pkg::count_t binary; // bits still to shift in
	duration_timer_pkg::bcd_t work;
	duration_timer_pkg::bcd_t adjusted;
	logic [4:0] step;

	// add 3 to every digit of 5 or more before the shift
	always_comb begin
		adjusted = work;
		for (int i = 0; i < `BCD_DIGITS; i++) begin
			if (work[4*i +: 4] >= 4'd5) begin
				adjusted[4*i +: 4] = work[4*i +: 4] + 4'd3;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= duration_timer_pkg::convert_idle;
			convert_ack <= 1'b0;
			step <= '0;
		end else begin
			case (state)
				duration_timer_pkg::convert_idle: begin
					if (convert_req) begin // load
						binary <= convert_value;
						work <= '0;
						step <= '0;
						state <= duration_timer_pkg::convert_shift;
					end
				end
				duration_timer_pkg::convert_shift: begin
					if (step == 5'($bits(duration_timer_pkg::count_t))) begin
						convert_result <= work;
						state <= duration_timer_pkg::convert_done;
					end else begin
						work <= {adjusted[22:0], binary[19]};
						binary <= {binary[18:0], 1'b0};
						step <= step + 5'd1;
					end
				end
				duration_timer_pkg::convert_done: begin
					convert_ack <= 1'b1;
					if (convert_ack && !convert_req) begin
						convert_ack <= 1'b0;
						state <= duration_timer_pkg::convert_idle;
					end
				end
				default: state <= duration_timer_pkg::convert_idle;
			endcase
		end
	end

	function automatic logic digits_valid(input duration_timer_pkg::bcd_t value);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < `BCD_DIGITS; i++) begin
			if (value[4*i +: 4] > 4'd9) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	assert property (@(posedge clock) disable iff (reset)
		$rose(convert_ack) |-> digits_valid(convert_result))
		else $error("bcd digit out of range at ack");

endmodule

`default_nettype wire

// ==== hw/duration_timer_params.svh ====
/*
 * widths, limits and reset values of the pulse duration timer
 * register addresses and display scan rate
 */
`ifndef DURATION_TIMER_PARAMS_SVH
`define DURATION_TIMER_PARAMS_SVH

`default_nettype none

`define COUNT_LIMIT 20'd999999 // saturation value of duration and count
`define BCD_DIGITS 6
`define LINE_LENGTH 15 // six digits, space, six digits, cr, lf
`define DEFAULT_BAUD_DIVISOR 16'd868
`define SCAN_DIVIDER_BITS 10 // 1024 cycles per display digit

`define ADDR_BAUD 2'd0
`define ADDR_CONTROL 2'd1
`define ADDR_STATUS 2'd2 // read only

`default_nettype wire

`endif

// ==== hw/duration_timer_pkg.sv ====
/*
 * shared types of the pulse duration timer
 * value widths and the state machine encodings
 */
`default_nettype none

package duration_timer_pkg;

	typedef logic [19:0] count_t; // duration in cycles or pulse count
	typedef logic [23:0] bcd_t; // six packed bcd digits
	typedef logic [7:0] byte_t;
	typedef logic [15:0] divisor_t; // clock cycles per uart bit
	typedef logic [1:0] cfg_address_t;
	typedef logic [15:0] cfg_data_t;

	typedef enum logic [1:0] {
		convert_idle,
		convert_shift,
		convert_done
	} convert_state_t;

	typedef enum logic [1:0] {
		report_idle,
		report_convert,
		report_send,
		report_wait_ack
	} report_state_t;

	typedef enum logic [2:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop,
		tx_done
	} tx_state_t;

endpackage

`default_nettype wire

// ==== hw/duration_timer_top.sv ====
/*
 * pulse duration timer top level
 * meter, report path with converter and uart, display, register block
 */
`timescale 1ns/1ps
`default_nettype none

module duration_timer_top (
	input wire clock,
	input wire reset,
	input wire trigger,
	input wire cfg_write,
	input duration_timer_pkg::cfg_address_t cfg_address,
	input duration_timer_pkg::cfg_data_t cfg_write_data,
	output duration_timer_pkg::cfg_data_t cfg_read_data,
	output logic tx,
	output logic [6:0] segment,
	output logic [3:0] anode
);

	duration_timer_pkg::divisor_t baud_divisor;
	logic report_enable;
	logic display_select;
	logic line_busy;
	logic measure_done;
	duration_timer_pkg::count_t duration;
	duration_timer_pkg::count_t pulse_count;
	logic convert_req;
	logic convert_ack;
	duration_timer_pkg::count_t convert_value;
	duration_timer_pkg::bcd_t convert_result;
	logic tx_req;
	logic tx_ack;
	duration_timer_pkg::byte_t tx_byte;
	duration_timer_pkg::bcd_t duration_bcd;
	duration_timer_pkg::bcd_t count_bcd;

	timer_config config_regs (.clock(clock), .reset(reset), .cfg_write(cfg_write),
		.cfg_address(cfg_address), .cfg_write_data(cfg_write_data), .line_busy(line_busy),
		.pulse_count(pulse_count), .cfg_read_data(cfg_read_data), .baud_divisor(baud_divisor),
		.report_enable(report_enable), .display_select(display_select));

	pulse_duration_meter meter (.clock(clock), .reset(reset), .trigger(trigger),
		.measure_done(measure_done), .duration(duration), .pulse_count(pulse_count));

	bin_to_bcd converter (.clock(clock), .reset(reset), .convert_req(convert_req),
		.convert_value(convert_value), .convert_ack(convert_ack),
		.convert_result(convert_result));

	report_formatter formatter (.clock(clock), .reset(reset), .report_enable(report_enable),
		.measure_done(measure_done), .duration(duration), .pulse_count(pulse_count),
		.convert_ack(convert_ack), .convert_result(convert_result), .tx_ack(tx_ack),
		.line_busy(line_busy), .convert_req(convert_req), .convert_value(convert_value),
		.tx_req(tx_req), .tx_byte(tx_byte), .duration_bcd(duration_bcd),
		.count_bcd(count_bcd));

	uart_tx transmitter (.clock(clock), .reset(reset), .baud_divisor(baud_divisor),
		.tx_req(tx_req), .tx_byte(tx_byte), .tx_ack(tx_ack), .tx(tx));

	segment_display display (.clock(clock), .reset(reset), .display_select(display_select),
		.duration_bcd(duration_bcd), .count_bcd(count_bcd), .segment(segment),
		.anode(anode));

endmodule

`default_nettype wire

// ==== hw/pulse_duration_meter.sv ====
/*
 * trigger synchronizer and edge detector
 * saturating pulse duration and pulse count
 */
`timescale 1ns/1ps
`include "duration_timer_params.svh"
`default_nettype none

module pulse_duration_meter (
	input wire clock,
	input wire reset,
	input wire trigger,
	output logic measure_done,
	output duration_timer_pkg::count_t duration,
	output duration_timer_pkg::count_t pulse_count
);

	// bits 1:0 form the synchronizer, bit 2 holds the previous level
	logic [2:0] history;
	logic level;
	logic rise;
	logic fall;
	duration_timer_pkg::count_t high_cycles; // length of the pulse in progress

	assign level = history[1];
	assign rise = history[1] & ~history[2]; // 01 pattern
	assign fall = history[2] & ~history[1]; // 10 pattern

	always_ff @(posedge clock) begin
		if (reset) begin
			history <= 3'b000;
			high_cycles <= '0;
			pulse_count <= '0;
			measure_done <= 1'b0;
		end else begin
			history <= {history[1:0], trigger};
			measure_done <= fall;

			if (rise) begin
				high_cycles <= 20'd1; // first high cycle
			end else if (level && high_cycles != `COUNT_LIMIT) begin
				high_cycles <= high_cycles + 20'd1;
			end

			if (fall && pulse_count != `COUNT_LIMIT) begin
				pulse_count <= pulse_count + 20'd1;
			end
		end
	end

	// captured with the same edge that raises measure_done
	always_ff @(posedge clock) begin
		if (fall) begin
			duration <= high_cycles;
		end
	end

endmodule

`default_nettype wire

// ==== hw/report_formatter.sv ====
/*
 * per-pulse report sequencer
 * converts duration and count, keeps the bcd results, sends the text line
 */
`timescale 1ns/1ps
`include "duration_timer_params.svh"
`default_nettype none

module report_formatter (
	input wire clock,
	input wire reset,
	input wire report_enable,
	input wire measure_done,
	input duration_timer_pkg::count_t duration,
	input duration_timer_pkg::count_t pulse_count,
	input wire convert_ack,
	input duration_timer_pkg::bcd_t convert_result,
	input wire tx_ack,
	output logic line_busy,
	output logic convert_req,
	output duration_timer_pkg::count_t convert_value,
	output logic tx_req,
	output duration_timer_pkg::byte_t tx_byte,
	output duration_timer_pkg::bcd_t duration_bcd,
	output duration_timer_pkg::bcd_t count_bcd
);

	duration_timer_pkg::report_state_t state;
	duration_timer_pkg::count_t count_snapshot; // duration snapshot sits in convert_value
	logic second_pass; // set while the count is converted
	logic [3:0] char_index;

	function automatic duration_timer_pkg::byte_t line_char(input logic [3:0] index,
			input duration_timer_pkg::bcd_t first, input duration_timer_pkg::bcd_t second);
		duration_timer_pkg::byte_t result;
		if (index < 4'd6) begin
			result = {4'h3, first[4*(5 - index) +: 4]}; // most significant digit first
		end else if (index == 4'd6) begin
			result = 8'h20;
		end else if (index < 4'd13) begin
			result = {4'h3, second[4*(12 - index) +: 4]};
		end else if (index == 4'd13) begin
			result = 8'h0d;
		end else begin
			result = 8'h0a;
		end
		return result;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= duration_timer_pkg::report_idle;
			line_busy <= 1'b0;
			convert_req <= 1'b0;
			tx_req <= 1'b0;
			second_pass <= 1'b0;
			char_index <= '0;
			duration_bcd <= '0;
			count_bcd <= '0;
		end else begin
			case (state)
				duration_timer_pkg::report_idle: begin
					if (measure_done && report_enable) begin
						convert_value <= duration;
						count_snapshot <= pulse_count;
						convert_req <= 1'b1;
						second_pass <= 1'b0;
						line_busy <= 1'b1;
						state <= duration_timer_pkg::report_convert;
					end
				end
				duration_timer_pkg::report_convert: begin
					if (convert_req && convert_ack) begin
						convert_req <= 1'b0;
						if (second_pass) count_bcd <= convert_result;
						else duration_bcd <= convert_result;
					end else if (!convert_req && !convert_ack) begin // handshake closed
						if (!second_pass) begin
							convert_value <= count_snapshot;
							convert_req <= 1'b1;
							second_pass <= 1'b1;
						end else begin
							char_index <= '0;
							state <= duration_timer_pkg::report_send;
						end
					end
				end
				duration_timer_pkg::report_send: begin
					if (!tx_ack) begin
						tx_byte <= line_char(char_index, duration_bcd, count_bcd);
						tx_req <= 1'b1;
						state <= duration_timer_pkg::report_wait_ack;
					end
				end
				duration_timer_pkg::report_wait_ack: begin
					if (tx_ack) begin
						tx_req <= 1'b0;
						if (char_index == 4'(`LINE_LENGTH - 1)) begin
							line_busy <= 1'b0; // end of line
							state <= duration_timer_pkg::report_idle;
						end else begin
							char_index <= char_index + 4'd1;
							state <= duration_timer_pkg::report_send;
						end
					end
				end
				default: state <= duration_timer_pkg::report_idle;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset) (tx_req && !tx_ack) |=> tx_req)
		else $error("tx_req dropped before tx_ack");

endmodule

`default_nettype wire

// ==== hw/segment_display.sv ====
/*
 * four digit multiplexed seven-segment driver with digit decoder
 */
`timescale 1ns/1ps
`include "duration_timer_params.svh"
`default_nettype none

module segment_display (
	input wire clock,
	input wire reset,
	input wire display_select,
	input duration_timer_pkg::bcd_t duration_bcd,
	input duration_timer_pkg::bcd_t count_bcd,
	output logic [6:0] segment,
	output logic [3:0] anode
);

	logic [`SCAN_DIVIDER_BITS+1:0] scan_counter;
	logic [1:0] digit_select;
	duration_timer_pkg::bcd_t shown;
	logic [3:0] digit;

	always_ff @(posedge clock) begin
		if (reset) scan_counter <= '0;
		else scan_counter <= scan_counter + 1'b1;
	end

	assign digit_select = scan_counter[`SCAN_DIVIDER_BITS +: 2];
	assign shown = display_select ? count_bcd : duration_bcd;
	assign digit = shown[4*digit_select +: 4]; // anode 0 is the units digit
	assign anode = 4'b0001 << digit_select;

	always_comb begin
		case (digit) // gfedcba
			4'd0: segment = 7'h3f;
			4'd1: segment = 7'h06;
			4'd2: segment = 7'h5b;
			4'd3: segment = 7'h4f;
			4'd4: segment = 7'h66;
			4'd5: segment = 7'h6d;
			4'd6: segment = 7'h7d;
			4'd7: segment = 7'h07;
			4'd8: segment = 7'h7f;
			4'd9: segment = 7'h6f;
			default: segment = 7'h00; // blank
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/timer_config.sv ====
/*
 * register block with baud divisor, control bits and status readback
 */
`timescale 1ns/1ps
`include "duration_timer_params.svh"
`default_nettype none

module timer_config (
	input wire clock,
	input wire reset,
	input wire cfg_write,
	input duration_timer_pkg::cfg_address_t cfg_address,
	input duration_timer_pkg::cfg_data_t cfg_write_data,
	input wire line_busy,
	input duration_timer_pkg::count_t pulse_count,
	output duration_timer_pkg::cfg_data_t cfg_read_data,
	output duration_timer_pkg::divisor_t baud_divisor,
	output logic report_enable,
	output logic display_select
);

	always_ff @(posedge clock) begin
		if (reset) begin
			baud_divisor <= `DEFAULT_BAUD_DIVISOR;
			report_enable <= 1'b0;
			display_select <= 1'b0; // show duration
		end else if (cfg_write) begin
			case (cfg_address)
				`ADDR_BAUD: baud_divisor <= cfg_write_data;
				`ADDR_CONTROL: begin
					report_enable <= cfg_write_data[0];
					display_select <= cfg_write_data[1];
				end
				default: ; // status and spare address ignore writes
			endcase
		end
	end

	always_comb begin
		case (cfg_address)
			`ADDR_BAUD: cfg_read_data = baud_divisor;
			`ADDR_CONTROL: cfg_read_data = {14'd0, display_select, report_enable};
			`ADDR_STATUS: cfg_read_data = {pulse_count[11:0], 3'd0, line_busy};
			default: cfg_read_data = '0;
		endcase
	end

	// the uart needs at least two cycles per bit
	assert property (@(posedge clock) disable iff (reset) baud_divisor >= 16'd2)
		else $error("baud divisor below 2");

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
/*
 * 8N1 uart transmitter, runtime baud divisor, req/ack per byte
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input wire clock,
	input wire reset,
	input duration_timer_pkg::divisor_t baud_divisor,
	input wire tx_req,
	input duration_timer_pkg::byte_t tx_byte,
	output logic tx_ack,
	output logic tx
);

	duration_timer_pkg::tx_state_t state;
	duration_timer_pkg::divisor_t divisor; // held for the whole byte
	duration_timer_pkg::divisor_t bit_timer;
	duration_timer_pkg::byte_t shift;
	logic [2:0] bit_index;
	logic bit_end;

	assign bit_end = (bit_timer == divisor - 16'd1);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= duration_timer_pkg::tx_idle;
			tx <= 1'b1;
			tx_ack <= 1'b0;
			bit_timer <= '0;
			bit_index <= '0;
		end else begin
			bit_timer <= bit_end ? '0 : bit_timer + 16'd1;
			case (state)
				duration_timer_pkg::tx_idle: begin
					bit_timer <= '0;
					if (tx_req) begin
						shift <= tx_byte;
						divisor <= baud_divisor;
						tx <= 1'b0; // start bit
						state <= duration_timer_pkg::tx_start;
					end
				end
				duration_timer_pkg::tx_start: begin
					if (bit_end) begin
						tx <= shift[0]; // lsb first
						shift <= shift >> 1;
						bit_index <= '0;
						state <= duration_timer_pkg::tx_data;
					end
				end
				duration_timer_pkg::tx_data: begin
					if (bit_end) begin
						if (bit_index == 3'd7) begin
							tx <= 1'b1; // stop bit
							state <= duration_timer_pkg::tx_stop;
						end else begin
							tx <= shift[0];
							shift <= shift >> 1;
							bit_index <= bit_index + 3'd1;
						end
					end
				end
				duration_timer_pkg::tx_stop: begin
					if (bit_end) begin
						tx_ack <= 1'b1;
						state <= duration_timer_pkg::tx_done;
					end
				end
				duration_timer_pkg::tx_done: begin
					if (!tx_req) begin
						tx_ack <= 1'b0;
						state <= duration_timer_pkg::tx_idle;
					end
				end
				default: state <= duration_timer_pkg::tx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire
